// File: vlog.f
+incdir+source
+incdir+sim
source/mpu_pkg.sv
source/mpu_region_csr.sv
source/mpu_stack_tracker.sv
source/mpu_request_stage.sv
source/mpu_check_stage.sv
source/mpu_top.sv
sim/tb_mpu.sv

// File: Bender.yml
package:
  name: mpu

export_include_dirs:
  - source

sources:
  - source/mpu_pkg.sv
  - source/mpu_region_csr.sv
  - source/mpu_stack_tracker.sv
  - source/mpu_request_stage.sv
  - source/mpu_check_stage.sv
  - source/mpu_top.sv
  - target: test
    include_dirs:
      - sim
    files:
      - sim/tb_mpu.sv

// File: sim/tb_mpu_model.svh
`ifndef TB_MPU_MODEL_SVH
`define TB_MPU_MODEL_SVH

// Mirror of the region table as raw words
logic [31:0] model_table [`MPU_MAPS * `MPU_ROWS];
logic [15:0] model_entries [`MPU_PRIO_LEVELS];
logic [7:0]  model_last_prio;

function automatic int clamp_prio(input logic [7:0] prio);
    return (prio > `MPU_PRIO_LEVELS - 1) ? `MPU_PRIO_LEVELS - 1 : int'(prio);
endfunction

function automatic void reset_model();
    foreach (model_table[i]) begin
        model_table[i] = '0;
    end
    foreach (model_entries[i]) begin
        model_entries[i] = '0;
    end
    model_last_prio = '0;
endfunction

function automatic void apply_csr(input logic en, input logic [11:0] addr,
                                  input mpu_pkg::csr_op_e kind, input logic [31:0] data);
    int idx;
    idx = int'(addr) - int'(`MPU_CSR_BASE);
    if (!en || idx < 0 || idx >= `MPU_MAPS * `MPU_ROWS) begin
        return;                              // Outside the table
    end
    case (kind)
        mpu_pkg::CSR_WRITE: model_table[idx] = data;
        mpu_pkg::CSR_SET:   model_table[idx] = model_table[idx] | data;
        mpu_pkg::CSR_CLEAR: model_table[idx] = model_table[idx] & ~data;
        default: ;
    endcase
endfunction

// Entry pointer seen by a request, forwarded on a priority change
function automatic logic [15:0] entry_for(input logic [7:0] prio, input logic [15:0] cur_sp);
    return (prio != model_last_prio) ? cur_sp : model_entries[clamp_prio(prio)];
endfunction

function automatic void capture_sp(input logic [7:0] prio, input logic [15:0] cur_sp);
    if (prio != model_last_prio) begin
        model_entries[clamp_prio(prio)] = cur_sp;
    end
    model_last_prio = prio;
endfunction

function automatic logic expected_fault(input logic [15:0] addr, input logic [6:0] kind,
                                        input logic [3:0] task_id, input logic [15:0] entry);
    int          map_idx;
    logic [31:0] word;
    logic [16:0] top_addr;
    logic        is_load;
    logic        is_store;
    is_load  = kind == 7'b0000011;
    is_store = kind == 7'b0100011;
    if (!is_load && !is_store) begin
        return 1'b0;
    end
    if (addr >= `MPU_STACK_TOP && addr <= entry) begin
        return 1'b0;                         // On the stack
    end
    map_idx = (task_id < `MPU_MAPS) ? int'(task_id) : 0;
    for (int r = 0; r < `MPU_ROWS; r++) begin
        word     = model_table[map_idx * `MPU_ROWS + r];
        top_addr = {1'b0, word[31:16]} + 17'(word[15:2]);
        if (addr >= word[31:16] && {1'b0, addr} <= top_addr
                && (is_load ? word[0] : word[1])) begin
            return 1'b0;
        end
    end
    return 1'b1;
endfunction

`endif

// File: sim/tb_mpu.sv
`include "mpu_params.svh"

module tb_mpu;

    logic             clk;
    logic             reset;
    logic [15:0]      mem_address;
    logic [15:0]      sp;
    logic [6:0]       op;
    logic [7:0]       interrupt_prio;
    logic [3:0]       id;
    logic             csr_enable;
    logic [11:0]      csr_addr;
    mpu_pkg::csr_op_e csr_op;
    logic [31:0]      csr_data;
    logic             fault;
    logic             fault_d;

    logic        exp_q [$];              // Expected fault per sampling edge
    logic        exp_d;
    logic [15:0] model_ptr;
    int          fault_errors;
    int          fault_d_errors;
    int          other_errors;
    int          wait_cycles;

    localparam logic [6:0] OP_LOAD  = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;
    localparam logic [6:0] OP_ALU   = 7'b0110011;

    `include "tb_mpu_model.svh"

    mpu_top u_mpu_top (
        .clk,
        .reset,
        .mem_address,
        .sp,
        .op,
        .interrupt_prio,
        .id,
        .csr_enable,
        .csr_addr,
        .csr_op,
        .csr_data,
        .fault,
        .fault_d
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    function automatic logic [31:0] pack_region(input logic [15:0] base, input logic [13:0] len,
                                                input logic wr, input logic rd);
        return {base, len, wr, rd};
    endfunction

    task automatic write_csr(input logic [11:0] addr, input mpu_pkg::csr_op_e kind,
                             input logic [31:0] data);
        @(posedge clk);
        csr_enable <= 1'b1;
        csr_addr   <= addr;
        csr_op     <= kind;
        csr_data   <= data;
        op         <= OP_ALU;                // No access in the CSR cycle
    endtask

    task automatic issue(input logic [15:0] addr, input logic [6:0] kind,
                         input logic [3:0] task_id);
        @(posedge clk);
        csr_enable  <= 1'b0;
        mem_address <= addr;
        op          <= kind;
        id          <= task_id;
    endtask

    // Load at the new sp in the same cycle as the priority change
    task automatic change_priority(input logic [7:0] prio, input logic [15:0] new_sp);
        @(posedge clk);
        csr_enable     <= 1'b0;
        interrupt_prio <= prio;
        sp             <= new_sp;
        mem_address    <= new_sp;
        op             <= OP_LOAD;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            csr_enable <= 1'b0;
            op         <= OP_ALU;
        end
    endtask

    task automatic run_random(input int cycles);
        logic [31:0] pick;
        repeat (cycles) begin
            @(posedge clk);
            pick = $urandom;
            csr_enable <= pick[2:0] == 3'd0;
            csr_addr   <= 12'h3fe + 12'($urandom % 42);   // Some misses on both sides
            csr_op     <= mpu_pkg::csr_op_e'($urandom % 3);
            csr_data   <= pick[3] ? pack_region(16'($urandom % 4096), 14'($urandom % 512),
                                                pick[4], pick[5]) : $urandom;
            if (pick[8:6] == 3'd0) begin
                interrupt_prio <= 8'($urandom % 8);
            end
            sp          <= 16'(1200 + $urandom % 1024);
            id          <= 4'($urandom);
            mem_address <= 16'($urandom % 4096);
            case (pick[10:9])
                2'd0:    op <= OP_LOAD;
                2'd1:    op <= OP_STORE;
                2'd2:    op <= 7'($urandom);
                default: op <= OP_LOAD;
            endcase
        end
    endtask

    // Reference model sees the inputs the DUT samples at this edge
    always @(posedge clk) begin
        if (reset) begin
            reset_model();
            exp_q.delete();
            exp_q.push_back(1'b0);           // Pipeline holds no access after reset
            exp_q.push_back(1'b0);
        end else begin
            model_ptr = entry_for(interrupt_prio, sp);
            exp_q.push_back(expected_fault(mem_address, op, id, model_ptr));
            capture_sp(interrupt_prio, sp);
            apply_csr(csr_enable, csr_addr, csr_op, csr_data);
        end
    end

    // Compare away from the active edge
    always @(negedge clk) begin
        if (!reset && exp_q.size() >= 3) begin
            exp_d = exp_q.pop_front();
            assert (fault_d === exp_d) else begin
                fault_d_errors++;
                $display("Fail %0t: fault_d is %b, expected %b", $time, fault_d, exp_d);
            end
            assert (fault === exp_q[0]) else begin
                fault_errors++;
                $display("Fail %0t: fault is %b, expected %b", $time, fault, exp_q[0]);
            end
        end
    end

    initial begin
        void'($urandom(32'h1261be2d));
        fault_errors   = 0;
        fault_d_errors = 0;
        other_errors   = 0;
        reset          <= 1'b1;
        mem_address    <= '0;
        sp             <= '0;
        op             <= '0;
        interrupt_prio <= '0;
        id             <= '0;
        csr_enable     <= 1'b0;
        csr_addr       <= '0;
        csr_op         <= mpu_pkg::CSR_WRITE;
        csr_data       <= '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        assert (fault === 1'b0 && fault_d === 1'b0) else begin
            other_errors++;
            $display("Fail %0t: outputs not low after reset", $time);
        end

        // Everything outside the stack faults with an empty table
        issue(16'h0100, OP_LOAD, 4'd0);
        issue(16'h0200, OP_STORE, 4'd0);
        issue(16'h0300, OP_ALU, 4'd0);
        idle(3);

        // Read-only region 0x200..0x210 in map 0
        write_csr(12'h400, mpu_pkg::CSR_WRITE, pack_region(16'h0200, 14'd16, 1'b0, 1'b1));
        issue(16'h0200, OP_LOAD, 4'd0);
        issue(16'h0210, OP_LOAD, 4'd0);
        issue(16'h0208, OP_STORE, 4'd0);
        issue(16'h0211, OP_LOAD, 4'd0);

        // Set and clear on the permission bits, then out-of-table writes
        write_csr(12'h400, mpu_pkg::CSR_SET, 32'h2);
        issue(16'h0208, OP_STORE, 4'd0);
        write_csr(12'h400, mpu_pkg::CSR_CLEAR, 32'h1);
        issue(16'h0208, OP_LOAD, 4'd0);
        // Low offset bits of both addresses alias word 0
        write_csr(12'h3c0, mpu_pkg::CSR_WRITE, pack_region(16'h0000, 14'h3fff, 1'b1, 1'b1));
        write_csr(12'h440, mpu_pkg::CSR_WRITE, pack_region(16'h0000, 14'h3fff, 1'b1, 1'b1));
        issue(16'h0208, OP_LOAD, 4'd0);

        // Stack tracking and level sharing above 3
        change_priority(8'd1, 16'h0600);
        issue(16'h0500, OP_LOAD, 4'd0);
        issue(16'h0600, OP_STORE, 4'd0);
        issue(16'h0601, OP_STORE, 4'd0);
        issue(16'h04ff, OP_LOAD, 4'd0);
        change_priority(8'd5, 16'h0700);
        issue(16'h06f0, OP_LOAD, 4'd0);
        change_priority(8'd7, 16'h0580);
        issue(16'h06f0, OP_LOAD, 4'd0);
        change_priority(8'd1, 16'h0520);
        issue(16'h0580, OP_LOAD, 4'd0);
        issue(16'h0520, OP_LOAD, 4'd0);

        // Task selection where ids 9 and up use map 0
        write_csr(12'h409, mpu_pkg::CSR_WRITE, pack_region(16'h3000, 14'h100, 1'b1, 1'b1));
        issue(16'h3050, OP_LOAD, 4'd2);
        issue(16'h3050, OP_LOAD, 4'd3);
        write_csr(12'h402, mpu_pkg::CSR_WRITE, pack_region(16'h4000, 14'h10, 1'b1, 1'b1));
        issue(16'h4008, OP_LOAD, 4'd12);
        issue(16'h4008, OP_STORE, 4'd9);
        issue(16'h4008, OP_LOAD, 4'd8);
        issue(16'h4008, OP_LOAD, 4'd15);

        run_random(2000);
        idle(4);
        wait_cycles = 0;
        while ((fault !== 1'b0 || fault_d !== 1'b0) && wait_cycles < 20) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (fault !== 1'b0 || fault_d !== 1'b0) begin
            other_errors++;
            $display("Timed out waiting for the fault outputs to go idle");
        end

        $display("Error counts: fault %0d, fault_d %0d, other %0d",
                 fault_errors, fault_d_errors, other_errors);
        if (fault_errors + fault_d_errors + other_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: source/mpu_top.sv
`include "mpu_params.svh"

module mpu_top (
    input  logic             clk,
    input  logic             reset,
    input  logic [15:0]      mem_address,
    input  logic [15:0]      sp,
    input  logic [6:0]       op,
    input  logic [7:0]       interrupt_prio,
    input  logic [3:0]       id,
    input  logic             csr_enable,
    input  logic [11:0]      csr_addr,
    input  mpu_pkg::csr_op_e csr_op,
    input  logic [31:0]      csr_data,
    output logic             fault,
    output logic             fault_d
);

    mpu_pkg::region_word_u table_words [`MPU_MAPS * `MPU_ROWS];
    mpu_pkg::region_word_u req_map [`MPU_ROWS];
    logic [15:0] entry_ptr;
    logic [15:0] req_address;
    logic [6:0]  req_op;
    logic [15:0] req_entry_ptr;

    mpu_region_csr u_region_csr (
        .clk,
        .reset,
        .csr_enable,
        .csr_addr,
        .csr_op,
        .csr_data,
        .table_words
    );

    mpu_stack_tracker u_stack_tracker (
        .clk,
        .reset,
        .sp,
        .interrupt_prio,
        .entry_ptr
    );

    // Stage 1, register the access and the task's map
    mpu_request_stage u_request_stage (
        .clk,
        .reset,
        .mem_address,
        .op,
        .id,
        .entry_ptr,
        .table_words,
        .req_address,
        .req_op,
        .req_entry_ptr,
        .req_map
    );

    // Stage 2, region and stack checks
    mpu_check_stage u_check_stage (
        .clk,
        .reset,
        .req_address,
        .req_op,
        .req_entry_ptr,
        .req_map,
        .fault,
        .fault_d
    );

endmodule

// File: source/mpu_check_stage.sv
`include "mpu_params.svh"

module mpu_check_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [15:0]           req_address,
    input  logic [6:0]            req_op,
    input  logic [15:0]           req_entry_ptr,
    input  mpu_pkg::region_word_u req_map [`MPU_ROWS],
    output logic                  fault,
    output logic                  fault_d
);

    mpu_pkg::opcode_e   op_kind;
    logic               is_load;
    logic               is_store;
    logic               in_stack;
    logic [`MPU_ROWS-1:0] row_grant;
    logic               fault_next;

    assign op_kind = mpu_pkg::opcode_e'(req_op);

    always_comb begin
        is_load  = 1'b0;
        is_store = 1'b0;
        case (op_kind)
            mpu_pkg::LOAD:  is_load  = 1'b1;
            mpu_pkg::STORE: is_store = 1'b1;
            default: ;                       // Not a data access
        endcase
    end

    for (genvar r = 0; r < `MPU_ROWS; r++) begin : g_row
        logic [16:0] top_addr;
        logic        in_range;
        logic        perm_ok;

        // 17 bits wide so base + length never wraps
        assign top_addr = {1'b0, req_map[r].fields.base} + 17'(req_map[r].fields.length);
        assign in_range = (req_address >= req_map[r].fields.base)
                       && ({1'b0, req_address} <= top_addr);
        assign perm_ok  = (is_load && req_map[r].fields.read_en)
                       || (is_store && req_map[r].fields.write_en);
        assign row_grant[r] = in_range && perm_ok;
    end

    // Stack runs from the fixed top up to the entry pointer
    assign in_stack = (req_address >= 16'(`MPU_STACK_TOP))
                   && (req_address <= req_entry_ptr);

    assign fault_next = (is_load || is_store) && !in_stack && !(|row_grant);

    always_ff @(posedge clk) begin
        if (reset) begin
            fault   <= 1'b0;
            fault_d <= 1'b0;
        end else begin
            fault   <= fault_next;
            fault_d <= fault;     // One cycle later for the interrupt controller
        end
    end

endmodule

// File: source/mpu_request_stage.sv
`include "mpu_params.svh"

module mpu_request_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [15:0]           mem_address,
    input  logic [6:0]            op,
    input  logic [3:0]            id,
    input  logic [15:0]           entry_ptr,
    input  mpu_pkg::region_word_u table_words [`MPU_MAPS * `MPU_ROWS],
    output logic [15:0]           req_address,
    output logic [6:0]            req_op,
    output logic [15:0]           req_entry_ptr,
    output mpu_pkg::region_word_u req_map [`MPU_ROWS]
);

    logic [3:0] map_idx;
    mpu_pkg::region_word_u sel_map [`MPU_ROWS];

    // Unused task ids fall back to map 0
    assign map_idx = (id < 4'(`MPU_MAPS)) ? id : 4'd0;

    always_comb begin
        for (int r = 0; r < `MPU_ROWS; r++) begin
            sel_map[r] = table_words[int'(map_idx) * `MPU_ROWS + r];
        end
    end

    // Opcode is the only control field
    always_ff @(posedge clk) begin
        if (reset) begin
            req_op <= '0;                 // No access pending
        end else begin
            req_op <= op;
        end
    end

    always_ff @(posedge clk) begin
        req_address   <= mem_address;
        req_entry_ptr <= entry_ptr;
        req_map       <= sel_map;
    end

endmodule

// File: source/mpu_stack_tracker.sv
`include "mpu_params.svh"

module mpu_stack_tracker (
    input  logic        clk,
    input  logic        reset,
    input  logic [15:0] sp,
    input  logic [7:0]  interrupt_prio,
    output logic [15:0] entry_ptr
);

    logic [7:0]  last_prio;                          // Raw priority at the last edge
    logic [15:0] entries [`MPU_PRIO_LEVELS];
    logic [$clog2(`MPU_PRIO_LEVELS)-1:0] prio_level;
    logic        prio_changed;

    // Clamp to the tracked levels
    always_comb begin
        if (interrupt_prio > 8'(`MPU_PRIO_LEVELS - 1)) begin
            prio_level = $clog2(`MPU_PRIO_LEVELS)'(`MPU_PRIO_LEVELS - 1);
        end else begin
            prio_level = interrupt_prio[$clog2(`MPU_PRIO_LEVELS)-1:0];
        end
    end

    // Compare on the raw value, so 4 -> 5 still recaptures level 3
    assign prio_changed = interrupt_prio != last_prio;

    // Forward sp on the capture cycle for the handler's first access
    assign entry_ptr = prio_changed ? sp : entries[prio_level];

    always_ff @(posedge clk) begin
        if (reset) begin
            last_prio <= '0;
            entries   <= '{default: '0};
        end else begin
            last_prio <= interrupt_prio;
            if (prio_changed) begin
                entries[prio_level] <= sp;
            end
        end
    end

endmodule

// File: source/mpu_region_csr.sv
`include "mpu_params.svh"

module mpu_region_csr (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 csr_enable,
    input  logic [11:0]          csr_addr,
    input  mpu_pkg::csr_op_e     csr_op,
    input  logic [31:0]          csr_data,
    output mpu_pkg::region_word_u table_words [`MPU_MAPS * `MPU_ROWS]
);

    logic [11:0] word_offset;
    logic [$clog2(`MPU_MAPS * `MPU_ROWS)-1:0] word_idx;
    logic        addr_hit;
    logic [31:0] old_raw;
    logic [31:0] new_raw;

    // Flat address range, word = task id * rows + row
    assign word_offset = csr_addr - `MPU_CSR_BASE;
    // Addresses below the base wrap to large offsets and miss here too
    assign addr_hit = word_offset < 12'(`MPU_MAPS * `MPU_ROWS);
    assign word_idx = word_offset[$clog2(`MPU_MAPS * `MPU_ROWS)-1:0];

    always_comb begin
        old_raw = '0;
        if (addr_hit) begin
            old_raw = table_words[word_idx].raw;
        end
    end

    // Read-modify-write on the raw view
    always_comb begin
        case (csr_op)
            mpu_pkg::CSR_WRITE: new_raw = csr_data;
            mpu_pkg::CSR_SET:   new_raw = old_raw | csr_data;
            mpu_pkg::CSR_CLEAR: new_raw = old_raw & ~csr_data;
            default:            new_raw = old_raw;   // Unused encoding
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            // Zero length, no permissions, base 0
            table_words <= '{default: '0};
        end else if (csr_enable && addr_hit) begin
            table_words[word_idx].raw <= new_raw;
        end
    end

endmodule

// File: source/mpu_pkg.sv
package mpu_pkg;

    // Major opcodes that count as data accesses
    typedef enum logic [6:0] {
        LOAD  = 7'b0000011,
        STORE = 7'b0100011
    } opcode_e;

    // CSR operations on a region word
    typedef enum logic [1:0] {
        CSR_WRITE,
        CSR_SET,
        CSR_CLEAR
    } csr_op_e;

    // One region word, seen as raw CSR data or as its decoded fields
    typedef union packed {
        logic [31:0] raw;          // Target of set and clear
        struct packed {
            logic [15:0] base;     // First address of the region
            logic [13:0] length;   // Last address is base + length
            logic        write_en;
            logic        read_en;
        } fields;
    } region_word_u;

endpackage

// File: source/mpu_params.svh
`ifndef MPU_PARAMS_SVH
`define MPU_PARAMS_SVH

// Region table geometry
`define MPU_MAPS 9           // One map per task
`define MPU_ROWS 4           // Regions per map

// Interrupt priority levels with their own entry pointer
`define MPU_PRIO_LEVELS 4    // Higher priorities share the last level

// Lowest address of the task stack
`define MPU_STACK_TOP 1280

// CSR address of region word 0
`define MPU_CSR_BASE 12'h400

`endif
